// ==== elink_macros.svh ====
`ifndef ELINK_MACROS_SVH
`define ELINK_MACROS_SVH

//########################################
//# link geometry
//########################################

`define ELINK_PW 104       // reordered packet width
`define ELINK_SW 112       // raw sample, seven 16-bit words
`define ELINK_WORDS 7      // words in a full transaction

//########################################
//# receive queues
//########################################

// both peer queues share these
`define ELINK_QDEPTH 8     // entries per queue
`define ELINK_QTHRESH 6    // fill level that raises wait

`endif

// ==== elink_pkg.sv ====
`include "elink_macros.svh"

package elink_pkg;

   //########################################
   //# link vectors
   //########################################

   typedef logic [15:0]              word_t;    // one deserialized link word
   typedef logic [`ELINK_SW-1:0]     sample_t;  // seven words, wire order
   typedef logic [`ELINK_WORDS-1:0]  pointer_t; // one-hot word select

   // packet layout
   //   [0]      access
   //   [1]      write
   //   [3:2]    datamode
   //   [7:4]    ctrlmode
   //   [39:8]   dstaddr
   //   [71:40]  data
   //   [103:72] srcaddr
   typedef logic [`ELINK_PW-1:0]     packet_t;

   // fill count, one extra bit so a full queue is representable
   typedef logic [$clog2(`ELINK_QDEPTH+1)-1:0] qcount_t;

   //########################################
   //# arbiter
   //########################################

   typedef enum logic
   {
      last_wr, // write queue granted last
      last_rd  // read queue granted last
   } arb_state_t;

endpackage

// ==== erx_framer.sv ====
`timescale 1ns/1ps
`include "elink_macros.svh"

module erx_framer
  (
   input  logic               rx_lclk,
   input  logic               reset,
   input  logic               rxi_frame,  // frame level from the pins
   input  elink_pkg::word_t   rxi_data,   // deserialized word
   output elink_pkg::packet_t packet,     // reordered packet
   output logic               burst,      // packet is a burst follow-on
   output logic               wr_push,    // write queue strobe
   output logic               rd_push     // read queue strobe
   );

   localparam int burst_word = 3; // burst beats restart at data word

   logic                 frame_q;       // registered frame
   elink_pkg::word_t     data_q;        // word aligned with frame_q
   elink_pkg::pointer_t  pointer;       // one-hot slice select
   elink_pkg::sample_t   sample;        // raw words
   logic                 last_word;     // word 6 captured this cycle
   logic                 in_burst;      // a packet of this frame already done
   logic                 access;        // sample complete
   logic                 access_burst;  // burst flag travelling with access
   elink_pkg::packet_t   packet_nxt;    // field reorder of sample

   //########################################
   //# frame and word alignment
   //########################################

   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
         frame_q <= 1'b0;
      else
         frame_q <= rxi_frame;

   always_ff @(posedge rx_lclk)
      data_q <= rxi_data; // same stage as frame_q

   assign last_word = frame_q & pointer[`ELINK_WORDS-1];

   // pointer parks on word 0 while idle
   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
         pointer <= elink_pkg::pointer_t'(1);
      else if (~frame_q)
         pointer <= elink_pkg::pointer_t'(1);             // new frame
      else if (pointer[`ELINK_WORDS-1])
         pointer <= elink_pkg::pointer_t'(1) << burst_word; // next burst beat
      else
         pointer <= pointer << 1;                          // mid frame

   //########################################
   //# sample assembly
   //########################################

   always_ff @(posedge rx_lclk)
      if (frame_q)
      begin
         for (int i = 0; i < `ELINK_WORDS; i++)
            if (pointer[i])
               sample[16*i +: 16] <= data_q;
      end

   // set after the first packet of a frame, cleared when frame drops
   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
         in_burst <= 1'b0;
      else if (~frame_q)
         in_burst <= 1'b0;
      else if (last_word)
         in_burst <= 1'b1;

   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
         access <= 1'b0;
      else
         access <= last_word;

   always_ff @(posedge rx_lclk)
      if (last_word)
         access_burst <= in_burst; // old value, so first packet is not burst

   //########################################
   //# field reorder
   //########################################

   always_comb
   begin
      packet_nxt[0]       = sample[40];        // access
      packet_nxt[1]       = sample[41];        // write
      packet_nxt[3:2]     = sample[43:42];     // datamode
      packet_nxt[7:4]     = sample[15:12];     // ctrlmode
      // dstaddr straddles words 0..2
      packet_nxt[39:8]    = {sample[11:8], sample[23:16], sample[31:24],
                             sample[39:32], sample[47:44]};
      // data, bytes swapped on the wire
      packet_nxt[71:40]   = {sample[55:48], sample[63:56],
                             sample[71:64], sample[79:72]};
      packet_nxt[103:72]  = {sample[87:80], sample[95:88],
                             sample[103:96], sample[111:104]}; // srcaddr
   end

   always_ff @(posedge rx_lclk)
      if (access)
      begin
         packet <= packet_nxt;
         burst  <= access_burst;
      end

   // steer by write bit, valid with packet
   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
      begin
         wr_push <= 1'b0;
         rd_push <= 1'b0;
      end
      else
      begin
         wr_push <= access & packet_nxt[1];
         rd_push <= access & ~packet_nxt[1];
      end

endmodule

// ==== erx_queue.sv ====
`timescale 1ns/1ps
`include "elink_macros.svh"

module erx_queue
  (
   input  logic               rx_lclk,
   input  logic               reset,
   input  logic               push,         // store push_packet
   input  elink_pkg::packet_t push_packet,
   input  logic               push_burst,
   input  logic               pop,          // drop head
   output elink_pkg::packet_t head_packet,  // oldest entry
   output logic               head_burst,
   output logic               not_empty,
   output logic               wait_level    // back-pressure to sender
   );

   localparam int aw = $clog2(`ELINK_QDEPTH);

   elink_pkg::packet_t        mem [`ELINK_QDEPTH]; // packet storage
   logic [`ELINK_QDEPTH-1:0]  burst_mem;           // burst bit per entry
   logic [aw-1:0]             wr_idx;
   logic [aw-1:0]             rd_idx;
   elink_pkg::qcount_t        count;
   elink_pkg::qcount_t        count_nxt;

   // circular increment
   function automatic logic [aw-1:0] next_idx(input logic [aw-1:0] idx);
      return (idx == aw'(`ELINK_QDEPTH-1)) ? '0 : idx + 1'b1;
   endfunction

   //########################################
   //# storage
   //########################################

   always_ff @(posedge rx_lclk)
      if (push)
      begin
         mem[wr_idx]       <= push_packet;
         burst_mem[wr_idx] <= push_burst;
      end

   assign head_packet = mem[rd_idx];
   assign head_burst  = burst_mem[rd_idx];

   //########################################
   //# indexes and fill level
   //########################################

   // no overflow guard, sender honors wait_level
   assign count_nxt = count + elink_pkg::qcount_t'(push) - elink_pkg::qcount_t'(pop);

   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
      begin
         wr_idx     <= '0;
         rd_idx     <= '0;
         count      <= '0;
         wait_level <= 1'b0;
      end
      else
      begin
         if (push)
            wr_idx <= next_idx(wr_idx);
         if (pop)
            rd_idx <= next_idx(rd_idx);
         count      <= count_nxt;
         wait_level <= (count_nxt >= elink_pkg::qcount_t'(`ELINK_QTHRESH)); // tracks count
      end

   assign not_empty = (count != '0);

endmodule

// ==== erx_arbiter.sv ====
`timescale 1ns/1ps

module erx_arbiter
  (
   input  logic               rx_lclk,
   input  logic               reset,
   input  logic               core_wait,     // stall from core
   input  logic               wr_not_empty,
   input  elink_pkg::packet_t wr_packet,     // write queue head
   input  logic               wr_burst,
   input  logic               rd_not_empty,
   input  elink_pkg::packet_t rd_packet,     // read queue head
   input  logic               rd_burst,
   output logic               wr_pop,
   output logic               rd_pop,
   output logic               rx_access,     // one-cycle valid
   output elink_pkg::packet_t rx_packet,
   output logic               rx_burst
   );

   elink_pkg::arb_state_t last_grant; // who won last time
   logic                  grant_wr;
   logic                  grant_rd;

   //########################################
   //# round robin
   //########################################

   always_comb
   begin
      grant_wr = 1'b0;
      grant_rd = 1'b0;
      if (~core_wait)
      begin
         if (wr_not_empty & rd_not_empty)
         begin
            // both pending, other side goes
            grant_wr = (last_grant == elink_pkg::last_rd);
            grant_rd = (last_grant == elink_pkg::last_wr);
         end
         else
         begin
            grant_wr = wr_not_empty;
            grant_rd = rd_not_empty;
         end
      end
   end

   assign wr_pop = grant_wr;
   assign rd_pop = grant_rd;

   always_ff @(posedge rx_lclk or posedge reset)
      if (reset)
      begin
         last_grant <= elink_pkg::last_rd; // writes win first tie
         rx_access  <= 1'b0;
      end
      else
      begin
         if (grant_wr)
            last_grant <= elink_pkg::last_wr;
         else if (grant_rd)
            last_grant <= elink_pkg::last_rd;
         rx_access <= grant_wr | grant_rd;
      end

   // outgoing bus payload
   always_ff @(posedge rx_lclk)
      if (grant_wr | grant_rd)
      begin
         rx_packet <= grant_wr ? wr_packet : rd_packet;
         rx_burst  <= grant_wr ? wr_burst : rd_burst;
      end

endmodule

// ==== erx_top.sv ====
`timescale 1ns/1ps

module erx_top
  (
   input  logic               rx_lclk,
   input  logic               reset,
   input  logic               rxi_frame,
   input  elink_pkg::word_t   rxi_data,
   input  logic               core_wait,
   output logic               rx_access,
   output elink_pkg::packet_t rx_packet,
   output logic               rx_burst,
   output logic               rxo_wr_wait,
   output logic               rxo_rd_wait
   );

   elink_pkg::packet_t packet;        // framer output
   logic               burst;
   logic               wr_push;
   logic               rd_push;
   logic               wr_pop;
   logic               rd_pop;
   logic               wr_not_empty;
   logic               rd_not_empty;
   elink_pkg::packet_t wr_packet;     // write queue head
   elink_pkg::packet_t rd_packet;     // read queue head
   logic               wr_burst;
   logic               rd_burst;

   //########################################
   //# receive path
   //########################################

   erx_framer framer_i
     (.rx_lclk (rx_lclk), .reset (reset), .rxi_frame (rxi_frame), .rxi_data (rxi_data),
      .packet (packet), .burst (burst), .wr_push (wr_push), .rd_push (rd_push));

   erx_queue wr_queue_i // writes only
     (.rx_lclk (rx_lclk), .reset (reset), .push (wr_push), .push_packet (packet),
      .push_burst (burst), .pop (wr_pop), .head_packet (wr_packet),
      .head_burst (wr_burst), .not_empty (wr_not_empty), .wait_level (rxo_wr_wait));

   erx_queue rd_queue_i // reads only
     (.rx_lclk (rx_lclk), .reset (reset), .push (rd_push), .push_packet (packet),
      .push_burst (burst), .pop (rd_pop), .head_packet (rd_packet),
      .head_burst (rd_burst), .not_empty (rd_not_empty), .wait_level (rxo_rd_wait));

   erx_arbiter arbiter_i
     (.rx_lclk (rx_lclk), .reset (reset), .core_wait (core_wait),
      .wr_not_empty (wr_not_empty), .wr_packet (wr_packet), .wr_burst (wr_burst),
      .rd_not_empty (rd_not_empty), .rd_packet (rd_packet), .rd_burst (rd_burst),
      .wr_pop (wr_pop), .rd_pop (rd_pop), .rx_access (rx_access),
      .rx_packet (rx_packet), .rx_burst (rx_burst));

endmodule

// ==== erx_checker.sv ====
`timescale 1ns/1ps

module erx_checker
  (
   input  logic               rx_lclk,
   input  logic               reset,
   input  logic               rx_access,
   input  elink_pkg::packet_t rx_packet,
   input  logic               rx_burst,
   input  logic               rxo_wr_wait,
   input  logic               rxo_rd_wait
   );

   elink_pkg::packet_t wr_exp_q [$];   // expected writes, send order
   elink_pkg::packet_t rd_exp_q [$];   // expected reads
   logic               wr_burst_q [$];
   logic               rd_burst_q [$];
   int                 data_errors = 0;  // wrong or missing packets
   int                 wait_errors = 0;  // wrong wait levels
   int                 order_errors = 0; // alternation broken
   int                 received = 0;
   logic               alt_check = 1'b0; // round-robin watch on
   longint             cycle = 0;
   longint             last_cycle = -10;
   logic               last_wr = 1'b0;

   //########################################
   //# interface for the testbench
   //########################################

   task automatic expect_packet(input elink_pkg::packet_t pkt, input logic burst);
      if (pkt[1])
      begin
         wr_exp_q.push_back(pkt);
         wr_burst_q.push_back(burst);
      end
      else
      begin
         rd_exp_q.push_back(pkt);
         rd_burst_q.push_back(burst);
      end
   endtask

   function automatic int pending();
      return wr_exp_q.size() + rd_exp_q.size();
   endfunction

   task automatic set_alt_check(input logic on);
      alt_check = on;
   endtask

   // sampled mid-cycle, away from the driving edge
   task automatic check_waits(input logic exp_wr, input logic exp_rd);
      @(negedge rx_lclk);
      if (rxo_wr_wait !== exp_wr || rxo_rd_wait !== exp_rd)
      begin
         wait_errors++;
         $display("[FAIL] %0t ns wait levels wr=%b rd=%b, expected wr=%b rd=%b",
                  $time, rxo_wr_wait, rxo_rd_wait, exp_wr, exp_rd);
      end
   endtask

   //########################################
   //# bus monitor
   //########################################

   always @(negedge rx_lclk)
   begin
      elink_pkg::packet_t exp_pkt;
      logic               exp_burst;
      cycle++;
      if (!reset && rx_access === 1'b1)
      begin
         received++;
         if (rx_packet[1] ? wr_exp_q.size() == 0 : rd_exp_q.size() == 0)
         begin
            data_errors++;
            $display("Packet %h arrived at %0t ns but none of its type was expected",
                     rx_packet, $time);
         end
         else
         begin
            if (rx_packet[1])
            begin
               exp_pkt   = wr_exp_q.pop_front();
               exp_burst = wr_burst_q.pop_front();
            end
            else
            begin
               exp_pkt   = rd_exp_q.pop_front();
               exp_burst = rd_burst_q.pop_front();
            end
            if (rx_packet !== exp_pkt || rx_burst !== exp_burst)
            begin
               data_errors++;
               $display("[FAIL] %0t ns packet %h burst %b, expected %h burst %b",
                        $time, rx_packet, rx_burst, exp_pkt, exp_burst);
            end
         end
         // back to back grants mean both queues were pending
         if (alt_check && last_cycle == cycle - 1 && last_wr == rx_packet[1])
         begin
            order_errors++;
            $display("[FAIL] %0t ns two grants in a row to the same queue", $time);
         end
         last_cycle = cycle;
         last_wr    = rx_packet[1];
      end
   end

endmodule

// ==== erx_sva.sv ====
`timescale 1ns/1ps

module erx_sva
  (
   input logic rx_lclk,
   input logic reset,
   input logic core_wait,
   input logic rx_access,
   input logic wr_push,
   input logic rd_push,
   input logic rxo_wr_wait,
   input logic rxo_rd_wait
   );

   int fail_count = 0; // failed assertions so far

   // stall from core blocks the next strobe
   stall_holds_access: assert property (@(posedge rx_lclk) disable iff (reset)
      $past(core_wait) |-> !rx_access)
      else
      begin
         fail_count++;
         $error("rx_access after a cycle with core_wait high");
      end

   one_push_only: assert property (@(posedge rx_lclk) disable iff (reset)
      !(wr_push && rd_push))
      else
      begin
         fail_count++;
         $error("wr_push and rd_push high together");
      end

   reset_quiet: assert property (@(posedge rx_lclk)
      reset |-> (!rx_access && !rxo_wr_wait && !rxo_rd_wait))
      else
      begin
         fail_count++;
         $error("outputs active during reset");
      end

endmodule

bind erx_top erx_sva sva_i (.*);

// ==== erx_tb.sv ====
`timescale 1ns/1ps
`include "elink_macros.svh"

module erx_tb;

   typedef struct {
      logic        wr;
      logic [1:0]  dmode;
      logic [3:0]  cmode;
      logic [31:0] dst;
      int          beats;  // extra burst beats
      int          gap;    // idle cycles after the frame
      logic        cw;     // core_wait during this entry
      logic        drain;  // wait for an empty checker after the entry
      logic        alt;    // watch round-robin during the entry
      logic        chk;    // compare wait levels at the end
      logic        exp_wr_wait;
      logic        exp_rd_wait;
   } entry_t;

   logic               rx_lclk = 1'b0;
   logic               reset = 1'b1;
   logic               rxi_frame = 1'b0;
   elink_pkg::word_t   rxi_data = '0;
   logic               core_wait = 1'b0;
   logic               rx_access;
   elink_pkg::packet_t rx_packet;
   logic               rx_burst;
   logic               rxo_wr_wait;
   logic               rxo_rd_wait;
   entry_t             stim_tab [$];
   integer             seed = 33342;
   int                 limit = 200;

   always #50 rx_lclk = ~rx_lclk;

   erx_top erx_top_i (.*);

   erx_checker checker_i
     (.rx_lclk (rx_lclk), .reset (reset), .rx_access (rx_access), .rx_packet (rx_packet),
      .rx_burst (rx_burst), .rxo_wr_wait (rxo_wr_wait), .rxo_rd_wait (rxo_rd_wait));

   task automatic add_entry(input logic wr, input logic [1:0] dm, input logic [3:0] cm,
                            input logic [31:0] dst, input int beats, input int gap,
                            input logic cw, input logic drain, input logic alt,
                            input logic chk, input logic ew, input logic er);
      entry_t e;
      e = '{wr, dm, cm, dst, beats, gap, cw, drain, alt, chk, ew, er};
      stim_tab.push_back(e);
   endtask

   // link word layout, fields into wire order
   function automatic elink_pkg::sample_t encode(input elink_pkg::packet_t p);
      elink_pkg::sample_t s;
      s = '0;
      s[40]       = p[0];
      s[41]       = p[1];
      s[43:42]    = p[3:2];
      s[15:12]    = p[7:4];
      s[11:8]     = p[39:36];  // dstaddr split over words 0..2
      s[23:16]    = p[35:28];
      s[31:24]    = p[27:20];
      s[39:32]    = p[19:12];
      s[47:44]    = p[11:8];
      s[55:48]    = p[71:64];  // data bytes
      s[63:56]    = p[63:56];
      s[71:64]    = p[55:48];
      s[79:72]    = p[47:40];
      s[87:80]    = p[103:96]; // srcaddr bytes
      s[95:88]    = p[95:88];
      s[103:96]   = p[87:80];
      s[111:104]  = p[79:72];
      return s;
   endfunction

   task automatic send_words(input elink_pkg::sample_t s, input int first);
      for (int i = first; i < `ELINK_WORDS; i++)
      begin
         @(posedge rx_lclk);
         rxi_frame <= 1'b1;
         rxi_data  <= s[16*i +: 16];
      end
   endtask

   task automatic run_entry(input entry_t e);
      elink_pkg::packet_t p;
      logic [31:0]        data;
      logic [31:0]        src;
      @(posedge rx_lclk);
      core_wait <= e.cw;
      if (e.alt)
         checker_i.set_alt_check(1'b1);
      for (int b = 0; b <= e.beats; b++)
      begin
         data = $random(seed);
         src  = $random(seed);
         p = {src, data, e.dst, e.cmode, e.dmode, e.wr, 1'b1};
         checker_i.expect_packet(p, b != 0);
         send_words(encode(p), (b == 0) ? 0 : 3); // beats restart at word 3
      end
      for (int g = 0; g < e.gap; g++)
      begin
         @(posedge rx_lclk);
         rxi_frame <= 1'b0;
      end
      if (e.drain)
      begin
         while (checker_i.pending() != 0)
            @(posedge rx_lclk);
         repeat (3) @(posedge rx_lclk);
      end
      if (e.alt)
         checker_i.set_alt_check(1'b0);
      if (e.chk)
         checker_i.check_waits(e.exp_wr_wait, e.exp_rd_wait);
   endtask

   initial
   begin
      int total;
      // 1 single write and single read
      add_entry(1, 2'd2, 4'h3, 32'h8000_1234, 0, 4, 0, 1, 0, 1, 0, 0);
      add_entry(0, 2'd1, 4'h5, 32'h0abc_def0, 0, 4, 0, 1, 0, 1, 0, 0);
      // 2 burst, one packet plus three beats
      add_entry(1, 2'd2, 4'h1, 32'h1000_0040, 3, 4, 0, 1, 0, 0, 0, 0);
      // 3 mixed back to back
      add_entry(1, 2'd0, 4'h0, 32'h2000_0000, 0, 1, 0, 0, 0, 0, 0, 0);
      add_entry(0, 2'd3, 4'h2, 32'h2000_0004, 0, 1, 0, 0, 0, 0, 0, 0);
      add_entry(0, 2'd1, 4'h4, 32'h2000_0008, 0, 1, 0, 0, 0, 0, 0, 0);
      add_entry(1, 2'd2, 4'h6, 32'h2000_000c, 0, 1, 0, 1, 0, 0, 0, 0);
      // 4 stall until the write queue asks to wait
      for (int i = 0; i < `ELINK_QTHRESH; i++)
         add_entry(1, 2'd2, 4'h0, 32'h3000_0000 + i, 0, 6, 1, 0, 0,
                   i == `ELINK_QTHRESH - 1, 1, 0);
      add_entry(0, 2'd2, 4'h7, 32'h3000_0100, 0, 4, 0, 1, 0, 1, 0, 0);
      // 5 both queues loaded, then released
      for (int i = 0; i < 6; i++)
         add_entry(i % 2 == 0, 2'd1, 4'h8, 32'h4000_0000 + i, 0, 2, 1, 0, 0, 0, 0, 0);
      add_entry(1, 2'd0, 4'h9, 32'h4000_0100, 0, 4, 0, 1, 1, 1, 0, 0);

      total = 0;
      foreach (stim_tab[i])
         total += 1 + `ELINK_WORDS + 4 * stim_tab[i].beats + stim_tab[i].gap;
      limit = total * 4 + 200;

      fork
         begin
            repeat (limit) @(posedge rx_lclk);
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
         end
      join_none

      repeat (3) @(posedge rx_lclk);
      reset <= 1'b0;
      repeat (2) @(posedge rx_lclk);

      foreach (stim_tab[i])
         run_entry(stim_tab[i]);

      repeat (5) @(posedge rx_lclk);
      if (checker_i.pending() != 0)
      begin
         checker_i.data_errors += checker_i.pending();
         $display("%0d expected packets never arrived", checker_i.pending());
      end
      $display("errors: packet=%0d wait=%0d order=%0d assert=%0d, packets received %0d",
               checker_i.data_errors, checker_i.wait_errors, checker_i.order_errors,
               erx_top_i.sva_i.fail_count, checker_i.received);
      if (checker_i.data_errors + checker_i.wait_errors + checker_i.order_errors
          + erx_top_i.sva_i.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
elink_pkg.sv
erx_framer.sv
erx_queue.sv
erx_arbiter.sv
erx_top.sv
erx_checker.sv
erx_sva.sv
erx_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module erx_tb -f files.f -o erx_sim

out=$(./obj_dir/erx_sim)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
   exit 0
else
   exit 1
fi
